//--- compile.f
hw/ctrl_bus_pkg.sv
hw/ctrl_periph_pkg.sv
hw/ctrl_regs.sv
hw/uart_tx.sv
hw/ms_timer.sv
hw/spi_ctrl_fsm.sv
hw/spi_shifter.sv
hw/ctrl_top.sv
dv/ctrl_top_sva.sv
dv/ctrl_top_tb.sv

//--- Bender.yml
package:
  name: ctrl_top

sources:
  - hw/ctrl_bus_pkg.sv
  - hw/ctrl_periph_pkg.sv
  - hw/ctrl_regs.sv
  - hw/uart_tx.sv
  - hw/ms_timer.sv
  - hw/spi_ctrl_fsm.sv
  - hw/spi_shifter.sv
  - hw/ctrl_top.sv
  - target: simulation
    files:
      - dv/ctrl_top_sva.sv
      - dv/ctrl_top_tb.sv

//--- dv/ctrl_top_tb.sv
/* testbench for the controller register block: table of register accesses,
   uart frame sampling, timer steps and spi loopback through spi_do */
`timescale 1ns/100ps

module ctrl_top_tb;
  import ctrl_bus_pkg::*;
  import ctrl_periph_pkg::*;

  localparam int         ack_timeout = 20000;
  localparam logic [1:0] op_wr       = 2'd0;
  localparam logic [1:0] op_wo       = 2'd1;
  localparam logic [1:0] op_rd       = 2'd2;

  logic       clk;
  logic       rst;
  qmem_req_t  bus_req;
  qmem_rsp_t  bus_rsp;
  logic [3:0] ctrl_cfg;
  logic       sys_rst;
  logic       core_rst;
  logic [3:0] ctrl_status;
  logic       uart_txd;
  logic [3:0] spi_cs_n;
  logic       spi_clk;
  logic       spi_do;
  logic       spi_di;

  int          errors;
  int          checks;
  logic [31:0] lfsr;

  // access table, one entry per index
  logic [1:0]  tab_op   [0:31];
  logic [2:0]  tab_reg  [0:31];
  logic [31:0] tab_dat  [0:31];
  logic [31:0] tab_exp  [0:31];
  string       tab_name [0:31];
  int          tab_len;

  ctrl_top ctrl_top_i (
    .clk         (clk),
    .rst         (rst),
    .bus_req     (bus_req),
    .bus_rsp     (bus_rsp),
    .ctrl_cfg    (ctrl_cfg),
    .sys_rst     (sys_rst),
    .core_rst    (core_rst),
    .ctrl_status (ctrl_status),
    .uart_txd    (uart_txd),
    .spi_cs_n    (spi_cs_n),
    .spi_clk     (spi_clk),
    .spi_do      (spi_do),
    .spi_di      (spi_di)
  );

  // spi loopback
  assign spi_di = spi_do;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers

  task automatic check(input string name, input logic [31:0] exp_val,
                       input logic [31:0] act_val);
    checks++;
    if (exp_val !== act_val) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  // ack is combinational, look at it mid-cycle
  task automatic wait_ack(input logic [2:0] idx);
    int n;
    n = 0;
    @(negedge clk);
    while (!bus_rsp.ack && (n < ack_timeout)) begin
      @(negedge clk);
      n++;
    end
    if (!bus_rsp.ack) begin
      errors++;
      $display("timeout: register %0d never acknowledged the access", idx);
    end
    // access completes on this edge
    @(posedge clk);
    bus_req <= '0;
  endtask

  task automatic bus_write(input logic [2:0] idx, input logic [31:0] data);
    qmem_req_t req;
    req          = '0;
    req.adr[4:0] = {idx, 2'b00};
    req.cs       = 1'b1;
    req.we       = 1'b1;
    req.dat_w    = data;
    @(posedge clk);
    bus_req <= req;
    wait_ack(idx);
  endtask

  task automatic bus_read(input logic [2:0] idx, output logic [31:0] data);
    qmem_req_t req;
    req          = '0;
    req.adr[4:0] = {idx, 2'b00};
    req.cs       = 1'b1;
    @(posedge clk);
    bus_req <= req;
    wait_ack(idx);
    // read data one cycle after ack
    @(negedge clk);
    data = bus_rsp.dat_r;
  endtask

  // output that a write to each local register shows up on
  function automatic logic [31:0] observe(input logic [2:0] idx);
    case (idx)
      reg_rst:    return {30'd0, core_rst, sys_rst};
      reg_ctrl:   return {28'd0, ctrl_status};
      reg_spi_cs: return {28'd0, spi_cs_n};
      default:    return '0;
    endcase
  endfunction

  task automatic add_entry(input logic [1:0] op, input logic [2:0] idx,
                           input logic [31:0] data, input logic [31:0] exp_val,
                           input string name);
    tab_op[tab_len]   = op;
    tab_reg[tab_len]  = idx;
    tab_dat[tab_len]  = data;
    tab_exp[tab_len]  = exp_val;
    tab_name[tab_len] = name;
    tab_len++;
  endtask

  ////////////////////////////////////////////////////////////
  // tests

  task automatic build_table(input logic [3:0] cfg);
    add_entry(op_wr, reg_rst, 32'h0000_0001, 32'h1, "sys reset on");
    add_entry(op_wr, reg_rst, 32'h0000_0002, 32'h2, "core reset only");
    add_entry(op_wr, reg_rst, 32'hffff_fffc, 32'h0, "upper bits ignored");
    add_entry(op_wr, reg_rst, 32'h0000_0003, 32'h3, "both resets");
    add_entry(op_wr, reg_rst, 32'h0000_0000, 32'h0, "resets released");
    // status lives in bits 18 to 15
    add_entry(op_wr, reg_ctrl, 32'h0002_8000, 32'h5, "status 5");
    add_entry(op_wr, reg_ctrl, 32'hfff8_7fff, 32'h0, "status field only");
    add_entry(op_wr, reg_ctrl, 32'h0005_0000, 32'ha, "status a");
    add_entry(op_rd, reg_ctrl, 32'h0, {28'd0, cfg}, "config readback");
    add_entry(op_rd, reg_spi_div, 32'h0, 32'd62, "default divider");
    add_entry(op_wo, reg_spi_div, 32'h3, 32'h0, "divider write");
    add_entry(op_rd, reg_spi_div, 32'h0, 32'h3, "divider readback");
    // unmasked, then masked chip selects
    add_entry(op_wr, reg_spi_cs, 32'h01, 32'he, "cs select 0");
    add_entry(op_wr, reg_spi_cs, 32'h0a, 32'h5, "cs select 1 and 3");
    add_entry(op_wr, reg_spi_cs, 32'h00, 32'hf, "cs all off");
    add_entry(op_wr, reg_spi_cs, 32'h31, 32'he, "cs masked low pair");
    add_entry(op_wr, reg_spi_cs, 32'h88, 32'h6, "cs masked line 3");
    add_entry(op_wr, reg_spi_cs, 32'h10, 32'h7, "cs masked release 0");
  endtask

  task automatic run_table();
    logic [31:0] rd;
    for (int i = 0; i < tab_len; i++) begin
      case (tab_op[i])
        op_rd: begin
          bus_read(tab_reg[i], rd);
          check(tab_name[i], tab_exp[i], rd);
        end
        op_wr: begin
          bus_write(tab_reg[i], tab_dat[i]);
          @(negedge clk);
          check(tab_name[i], tab_exp[i], observe(tab_reg[i]));
        end
        default: bus_write(tab_reg[i], tab_dat[i]);
      endcase
    end
  endtask

  task automatic reset_state();
    @(negedge clk);
    check("reset sys_rst", 32'h0, sys_rst);
    check("reset core_rst", 32'h0, core_rst);
    check("reset ctrl_status", 32'h0, ctrl_status);
    check("reset spi_cs_n", 32'hf, spi_cs_n);
    check("reset spi_clk", 32'h1, spi_clk);
    check("reset uart_txd", 32'h1, uart_txd);
    check("reset spi busy", 32'h0, ctrl_top_i.spi_busy);
  endtask

  // sample each bit in its middle, start edge is the write edge
  task automatic uart_frame(input logic [7:0] b);
    logic [9:0] frame;
    bus_write(reg_uart_tx, {24'd0, b});
    repeat (txd_cnt / 2) @(posedge clk);
    for (int k = 0; k < 10; k++) begin
      @(negedge clk);
      frame[k] = uart_txd;
      if (k < 9)
        repeat (txd_cnt) @(posedge clk);
    end
    check("uart start bit", 32'h0, frame[0]);
    check("uart data bits", {24'd0, b}, frame[8:1]);
    check("uart stop bit", 32'h1, frame[9]);
  endtask

  task automatic timer_test(input logic [15:0] v);
    logic [31:0] rd;
    bus_write(reg_timer, {16'd0, v});
    bus_read(reg_timer, rd);
    check("timer readback", {16'd0, v}, rd);
    // one full prescaler period
    for (int n = 0; n < timer_cnt; n++)
      @(posedge clk);
    bus_read(reg_timer, rd);
    check("timer tick", {16'd0, v + 16'd1}, rd);
  endtask

  // read of the data register stalls until the transfer ends
  task automatic spi_loop(input logic [9:0] block, input logic [7:0] b,
                          input logic [7:0] exp_val, input string name);
    logic [31:0] rd;
    bus_write(reg_spi_block, {22'd0, block});
    bus_write(reg_spi_dat, {24'd0, b});
    bus_read(reg_spi_dat, rd);
    check(name, {24'd0, exp_val}, rd);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    logic [31:0] r;
    logic [3:0]  cfg;
    errors   = 0;
    checks   = 0;
    tab_len  = 0;
    lfsr     = 32'hbb54_a4f5;
    rst      = 1'b1;
    bus_req  = '0;
    ctrl_cfg = 4'h0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    reset_state();

    take_bits(4, r);
    cfg = r[3:0];
    @(posedge clk);
    ctrl_cfg <= cfg;
    build_table(cfg);
    run_table();

    // second frame waits on the first one
    take_bits(8, r);
    uart_frame(r[7:0]);
    take_bits(8, r);
    uart_frame(r[7:0]);

    take_bits(16, r);
    timer_test(r[15:0]);

    take_bits(8, r);
    spi_loop(10'd0, r[7:0], r[7:0], "spi loopback block 0");
    // trailing bytes shift out as ones
    take_bits(8, r);
    spi_loop(10'd2, r[7:0], 8'hff, "spi loopback block 2");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

//--- dv/ctrl_top_sva.sv
/* concurrent checks on the controller top level, bound into ctrl_top */
`timescale 1ns/100ps

module ctrl_top_sva (
  input logic                    clk,
  input logic                    rst,
  input ctrl_bus_pkg::qmem_req_t bus_req,
  input ctrl_bus_pkg::qmem_rsp_t bus_rsp,
  input logic                    spi_busy,
  input logic                    spi_clk,
  input logic                    tx_idle,
  input logic                    uart_txd
);
  import ctrl_bus_pkg::*;

  // mode 3, clock parks high between transfers
  a_spi_clk_idle: assert property (
    @(posedge clk) disable iff (rst) !spi_busy |-> spi_clk
  ) else $error("spi clock low while no transfer is running");

  // line sits at mark level when nothing is sent
  a_uart_mark: assert property (
    @(posedge clk) disable iff (rst) tx_idle |-> uart_txd
  ) else $error("uart line low while the transmitter is idle");

  // uart data register stalls while a frame goes out
  // accepted write puts the start bit on the line next cycle
  a_uart_ack: assert property (
    @(posedge clk) disable iff (rst)
      (bus_rsp.ack && bus_req.we && (bus_req.adr[4:2] == reg_uart_tx))
        |-> tx_idle ##1 (!tx_idle && !uart_txd)
  ) else $error("uart write acknowledged while busy or without starting a frame");

endmodule

bind ctrl_top ctrl_top_sva ctrl_top_sva_i (
  .clk      (clk),
  .rst      (rst),
  .bus_req  (bus_req),
  .bus_rsp  (bus_rsp),
  .spi_busy (spi_busy),
  .spi_clk  (spi_clk),
  .tx_idle  (tx_idle),
  .uart_txd (uart_txd)
);

//--- hw/ctrl_top.sv
/* system controller register block: qmem decoder with uart transmitter,
   millisecond timer and spi master */
`timescale 1ns/100ps

module ctrl_top (
  input  logic                    clk,
  input  logic                    rst,
  input  ctrl_bus_pkg::qmem_req_t bus_req,
  output ctrl_bus_pkg::qmem_rsp_t bus_rsp,
  input  logic [3:0]              ctrl_cfg,
  output logic                    sys_rst,
  output logic                    core_rst,
  output logic [3:0]              ctrl_status,
  output logic                    uart_txd,
  output logic [3:0]              spi_cs_n,
  output logic                    spi_clk,
  output logic                    spi_do,
  input  logic                    spi_di
);
  import ctrl_periph_pkg::*;

  logic                 tx_start;
  logic [7:0]           tx_byte;
  logic                 tx_idle;
  logic                 tm_load;
  logic [15:0]          tm_val;
  logic [15:0]          tm_count;
  spi_cmd_t             spi_cmd;
  logic                 spi_run;
  logic                 spi_load;
  logic                 spi_busy;
  logic                 spi_half_tick;
  logic                 spi_byte_done;
  logic [7:0]           spi_rx;
  logic [spi_div_w-1:0] spi_div_r;

  // bus decode and local registers
  ctrl_regs ctrl_regs_i (
    .clk         (clk),
    .rst         (rst),
    .bus_req     (bus_req),
    .bus_rsp     (bus_rsp),
    .ctrl_cfg    (ctrl_cfg),
    .sys_rst     (sys_rst),
    .core_rst    (core_rst),
    .ctrl_status (ctrl_status),
    .spi_cs_n    (spi_cs_n),
    .tx_start    (tx_start),
    .tx_byte     (tx_byte),
    .tx_idle     (tx_idle),
    .tm_load     (tm_load),
    .tm_val      (tm_val),
    .tm_count    (tm_count),
    .spi_cmd     (spi_cmd),
    .spi_busy    (spi_busy),
    .spi_rx      (spi_rx),
    .spi_div_r   (spi_div_r)
  );

  uart_tx uart_tx_i (
    .clk      (clk),
    .rst      (rst),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .txd      (uart_txd),
    .tx_idle  (tx_idle)
  );

  ms_timer ms_timer_i (
    .clk      (clk),
    .rst      (rst),
    .tm_load  (tm_load),
    .tm_val   (tm_val),
    .tm_count (tm_count)
  );

  // end-of-transfer strobe is not needed at this level
  spi_ctrl_fsm spi_ctrl_fsm_i (
    .clk       (clk),
    .rst       (rst),
    .cmd       (spi_cmd),
    .half_tick (spi_half_tick),
    .byte_done (spi_byte_done),
    .run       (spi_run),
    .load      (spi_load),
    .tail_done (),
    .busy      (spi_busy),
    .div_r     (spi_div_r)
  );

  // divider and tx byte straight from the command fields
  spi_shifter spi_shifter_i (
    .clk       (clk),
    .rst       (rst),
    .run       (spi_run),
    .load      (spi_load),
    .div       (spi_cmd.div),
    .div_we    (spi_cmd.div_we),
    .dat       (spi_cmd.dat),
    .di        (spi_di),
    .sclk      (spi_clk),
    .do_bit    (spi_do),
    .half_tick (spi_half_tick),
    .byte_done (spi_byte_done),
    .rx_byte   (spi_rx)
  );

endmodule

//--- hw/spi_shifter.sv
/* spi mode 3 datapath: half-period divider, sclk edge counter and
   shift registers; msb first, ones shifted in behind the byte */
`timescale 1ns/100ps

module spi_shifter (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  run,
  input  logic                                  load,
  input  logic [ctrl_periph_pkg::spi_div_w-1:0] div,
  input  logic                                  div_we,
  input  logic [7:0]                            dat,
  input  logic                                  di,
  output logic                                  sclk,
  output logic                                  do_bit,
  output logic                                  half_tick,
  output logic                                  byte_done,
  output logic [7:0]                            rx_byte
);
  import ctrl_periph_pkg::*;

  logic [spi_div_w-1:0] div_q;
  logic [spi_div_w-1:0] cnt;
  logic [3:0]           edge_cnt;
  logic [8:0]           tx_sr;
  logic [7:0]           rx_sr;
  logic                 step;

  // divider reload value
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      div_q <= spi_cnt_dflt;
    else if (div_we)
      div_q <= div;
  end

  // counts down to zero, reloads only while running
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      cnt <= '0;
    else if (load || (run && (cnt == '0)))
      cnt <= div_q;
    else if (cnt != '0)
      cnt <= cnt - 1'b1;
  end

  assign half_tick = (cnt == '0);
  assign step      = run && half_tick;

  // 16 half-periods per byte, odd count = clock high
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      edge_cnt <= 4'hf;
    else if (step)
      edge_cnt <= edge_cnt - 4'd1;
  end

  assign sclk      = edge_cnt[0];
  assign byte_done = step && (edge_cnt == 4'd0);

  ////////////////////////////////////////////////////////////
  // data

  // extra top bit keeps do high until the first falling edge
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      tx_sr <= '1;
    else if (load)
      tx_sr <= {1'b1, dat};
    else if (step && sclk)
      tx_sr <= {tx_sr[7:0], 1'b1};
  end

  // sample on rising edge
  always_ff @(posedge clk) begin
    if (step && !sclk)
      rx_sr <= {rx_sr[6:0], di};
  end

  assign do_bit  = tx_sr[8];
  assign rx_byte = rx_sr;

endmodule

//--- hw/spi_ctrl_fsm.sv
/* spi transfer sequencer: starts the shifter, counts block bytes and
   holds busy through a closing half-period; keeps the readable divider */
`timescale 1ns/100ps

module spi_ctrl_fsm (
  input  logic                                  clk,
  input  logic                                  rst,
  input  ctrl_periph_pkg::spi_cmd_t             cmd,
  input  logic                                  half_tick,
  input  logic                                  byte_done,
  output logic                                  run,
  output logic                                  load,
  output logic                                  tail_done,
  output logic                                  busy,
  output logic [ctrl_periph_pkg::spi_div_w-1:0] div_r
);
  import ctrl_periph_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_shift,
    st_tail
  } state_t;

  state_t                 state;
  logic [spi_block_w-1:0] blk;

  ////////////////////////////////////////////////////////////
  // transfer state

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:  if (cmd.start) state <= st_shift;
        // last byte when block count is exhausted
        st_shift: if (byte_done && (blk == '0)) state <= st_tail;
        st_tail:  if (tail_done) state <= st_idle;
        default:  state <= st_idle;
      endcase
    end
  end

  // bytes remaining after the current one
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      blk <= '0;
    else if (cmd.block_we)
      blk <= cmd.block;
    else if ((state == st_shift) && byte_done && (blk != '0))
      blk <= blk - 1'b1;
  end

  // divider readback, written while idle
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      div_r <= spi_cnt_dflt;
    else if (cmd.div_we)
      div_r <= cmd.div;
  end

  ////////////////////////////////////////////////////////////
  // shifter control

  assign load      = (state == st_idle) && cmd.start;
  assign run       = (state == st_shift);
  // divider runs out once more after the last edge
  assign tail_done = (state == st_tail) && half_tick;
  assign busy      = (state != st_idle);

endmodule

//--- hw/ms_timer.sv
/* free running millisecond counter, preset by tm_load;
   a load also restarts the millisecond prescaler */
`timescale 1ns/100ps

module ms_timer (
  input  logic        clk,
  input  logic        rst,
  input  logic        tm_load,
  input  logic [15:0] tm_val,
  output logic [15:0] tm_count
);
  import ctrl_periph_pkg::*;

  logic [15:0] pre;

  // prescaler, wraps once per millisecond
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      pre <= timer_cnt - 16'd1;
    else if (tm_load || (pre == 16'd0))
      pre <= timer_cnt - 16'd1;
    else
      pre <= pre - 16'd1;
  end

  // counter steps on prescaler wrap
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      tm_count <= 16'd0;
    else if (tm_load)
      tm_count <= tm_val;
    else if (pre == 16'd0)
      tm_count <= tm_count + 16'd1;
  end

endmodule

//--- hw/uart_tx.sv
/* 8N1 uart transmitter, one byte per tx_start, no buffering;
   tx_idle must be high before the next start */
`timescale 1ns/100ps

module uart_tx (
  input  logic       clk,
  input  logic       rst,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       txd,
  output logic       tx_idle
);
  import ctrl_periph_pkg::*;

  logic [3:0] bit_cnt;
  logic [8:0] baud;
  logic [9:0] frame;

  // bits left after the current one
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      bit_cnt <= 4'd0;
    else if (tx_start)
      bit_cnt <= 4'd9;
    else if ((bit_cnt != 4'd0) && (baud == 9'd0))
      bit_cnt <= bit_cnt - 4'd1;
  end

  // baud counter, reloads at each bit boundary
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      baud <= 9'd0;
    else if (tx_start)
      baud <= txd_cnt - 9'd1;
    else if (baud != 9'd0)
      baud <= baud - 9'd1;
    else if (bit_cnt != 4'd0)
      baud <= txd_cnt - 9'd1;
  end

  // stop, data lsb first, start; ones shift in behind
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      frame <= '1;
    else if (tx_start)
      frame <= {1'b1, tx_byte, 1'b0};
    else if ((bit_cnt != 4'd0) && (baud == 9'd0))
      frame <= {1'b1, frame[9:1]};
  end

  assign txd     = frame[0];
  assign tx_idle = (bit_cnt == 4'd0) && (baud == 9'd0);

endmodule

//--- hw/ctrl_regs.sv
/* qmem register decoder: write strobes, reset/status/chip-select registers,
   read mux and the ack that stalls on a busy uart or spi */
`timescale 1ns/100ps

module ctrl_regs (
  input  logic                                clk,
  input  logic                                rst,
  input  ctrl_bus_pkg::qmem_req_t             bus_req,
  output ctrl_bus_pkg::qmem_rsp_t             bus_rsp,
  input  logic [3:0]                          ctrl_cfg,
  output logic                                sys_rst,
  output logic                                core_rst,
  output logic [3:0]                          ctrl_status,
  output logic [3:0]                          spi_cs_n,
  output logic                                tx_start,
  output logic [7:0]                          tx_byte,
  input  logic                                tx_idle,
  output logic                                tm_load,
  output logic [15:0]                         tm_val,
  input  logic [15:0]                         tm_count,
  output ctrl_periph_pkg::spi_cmd_t           spi_cmd,
  input  logic                                spi_busy,
  input  logic [7:0]                          spi_rx,
  input  logic [ctrl_periph_pkg::spi_div_w-1:0] spi_div_r
);
  import ctrl_bus_pkg::*;
  import ctrl_periph_pkg::*;

  logic [2:0]     idx;
  logic [2:0]     adr_r;
  logic           ack;
  logic [7:0]     wr_sel;
  logic [qdw-1:0] rd_dat;
  ctrl_wdata_u    wd;

  ////////////////////////////////////////////////////////////
  // decode

  // word index from byte address
  assign idx    = bus_req.adr[4:2];
  assign wd.raw = bus_req.dat_w;

  // uart and spi registers stall until their unit is free
  always_comb begin
    case (idx)
      reg_uart_tx: ack = bus_req.cs & tx_idle;
      reg_spi_div, reg_spi_cs, reg_spi_dat, reg_spi_block:
        ack = bus_req.cs & ~spi_busy;
      default: ack = bus_req.cs;
    endcase
  end

  // one-hot write strobe, only on an acked write
  assign wr_sel = (bus_req.cs && bus_req.we && ack) ? (8'b1 << idx) : 8'h00;

  ////////////////////////////////////////////////////////////
  // local registers

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sys_rst     <= 1'b0;
      core_rst    <= 1'b0;
      ctrl_status <= 4'h0;
      spi_cs_n    <= 4'hf;
    end else begin
      if (wr_sel[reg_rst]) begin
        sys_rst  <= wd.rst.sys_rst;
        core_rst <= wd.rst.core_rst;
      end
      if (wr_sel[reg_ctrl])
        ctrl_status <= wd.ctrl.status;
      // masked write touches only the selected lines
      if (wr_sel[reg_spi_cs]) begin
        if (|wd.cs.cs_mask)
          spi_cs_n <= (spi_cs_n & ~wd.cs.cs_mask) | (~wd.cs.cs_val & wd.cs.cs_mask);
        else
          spi_cs_n <= ~wd.cs.cs_val;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // peripheral strobes

  assign tx_start = wr_sel[reg_uart_tx];
  assign tx_byte  = wd.raw[7:0];
  assign tm_load  = wr_sel[reg_timer];
  assign tm_val   = wd.raw[15:0];

  assign spi_cmd.start    = wr_sel[reg_spi_dat];
  assign spi_cmd.dat      = wd.raw[7:0];
  assign spi_cmd.div      = wd.raw[spi_div_w-1:0];
  assign spi_cmd.div_we   = wr_sel[reg_spi_div];
  assign spi_cmd.block    = wd.raw[spi_block_w-1:0];
  assign spi_cmd.block_we = wr_sel[reg_spi_block];

  ////////////////////////////////////////////////////////////
  // read back

  // address of the last selected cycle, data follows ack by one clock
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      adr_r <= 3'd0;
    else if (bus_req.cs)
      adr_r <= idx;
  end

  always_comb begin
    case (adr_r)
      reg_ctrl:    rd_dat = qdw'(ctrl_cfg);
      reg_timer:   rd_dat = qdw'(tm_count);
      reg_spi_div: rd_dat = qdw'(spi_div_r);
      reg_spi_dat: rd_dat = qdw'(spi_rx);
      default:     rd_dat = '0;
    endcase
  end

  assign bus_rsp.dat_r = rd_dat;
  assign bus_rsp.ack   = ack;

endmodule

//--- hw/ctrl_periph_pkg.sv
/* peripheral constants for a 50 MHz clock, the decoded views of the
   bus write word and the SPI command passed from the decoder */
package ctrl_periph_pkg;

  // uart bit time, 115200 baud
  localparam logic [8:0] txd_cnt = 9'd434;
  // clocks per millisecond
  localparam logic [15:0] timer_cnt = 16'd50000;

  // spi divider and block count widths
  localparam int spi_div_w   = 6;
  localparam int spi_block_w = 10;
  // divider after reset, 400 kHz sd init clock
  localparam logic [spi_div_w-1:0] spi_cnt_dflt = 6'd62;

  // one write word, decoded per target register
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [29:0] rsvd;
      logic        core_rst;
      logic        sys_rst;
    } rst;
    struct packed {
      logic [12:0] rsvd_hi;
      logic [3:0]  status;
      logic [14:0] rsvd_lo;
    } ctrl;
    struct packed {
      logic [23:0] rsvd;
      logic [3:0]  cs_mask;
      logic [3:0]  cs_val;
    } cs;
  } ctrl_wdata_u;

  // write strobes and fields for the spi block
  typedef struct packed {
    logic                   start;
    logic [spi_div_w-1:0]   div;
    logic                   div_we;
    logic [spi_block_w-1:0] block;
    logic                   block_we;
    logic [7:0]             dat;
  } spi_cmd_t;

endpackage

//--- hw/ctrl_bus_pkg.sv
/* qmem bus widths, register map and bus request/response types,
   shared by the register decoder, the top level and the testbench */
package ctrl_bus_pkg;

  // qmem address and data widths
  localparam int qaw = 22;
  localparam int qdw = 32;

  // register indices, word at byte offset index*4
  localparam logic [2:0] reg_rst       = 3'd0;
  localparam logic [2:0] reg_ctrl      = 3'd1;
  localparam logic [2:0] reg_uart_tx   = 3'd2;
  localparam logic [2:0] reg_timer     = 3'd3;
  localparam logic [2:0] reg_spi_div   = 3'd4;
  localparam logic [2:0] reg_spi_cs    = 3'd5;
  localparam logic [2:0] reg_spi_dat   = 3'd6;
  localparam logic [2:0] reg_spi_block = 3'd7;

  // master side, held until ack
  typedef struct packed {
    logic [qaw-1:0] adr;
    logic           cs;
    logic           we;
    logic [qdw-1:0] dat_w;
  } qmem_req_t;

  // slave side, dat_r lags ack by one cycle
  typedef struct packed {
    logic [qdw-1:0] dat_r;
    logic           ack;
  } qmem_rsp_t;

endpackage
